//--- common/rob_pkg.sv
// ============================================================
// Reorder buffer shared definitions
// ============================================================
// Sizes, the entry index type and the payload structs used by
// the allocator, the completion tracker, the storage arrays and
// the top level

package rob_pkg;

    // ============================================================
    // Sizes
    // ============================================================

    // Number of buffer entries
    // Pointers wrap by overflow so this stays a power of two
    localparam int ROB_ENTRIES   = 16;

    // Width of an entry index
    localparam int ROB_IDX_BITS  = $clog2(ROB_ENTRIES);

    // Late payload width
    localparam int ROB_DATA_BITS = 32;

    // Tag captured at allocation time
    localparam int ROB_META_BITS = 8;

    // not_full stays high while at least this many entries are free
    localparam int ROB_MIN_FREE  = 1;

    // ============================================================
    // Types
    // ============================================================

    // Entry index, also the handle returned to the requester
    typedef logic [ROB_IDX_BITS-1:0] rob_idx_t;

    // Late payload write
    // The index is the one granted on alloc_idx
    typedef struct packed {
        rob_idx_t                 idx;
        logic [ROB_DATA_BITS-1:0] data;
    } rob_enq_t;

    // Ordered output word
    // Data and the meta tag of the same entry side by side
    typedef struct packed {
        logic [ROB_DATA_BITS-1:0] data;
        logic [ROB_META_BITS-1:0] meta;
    } rob_first_t;

endpackage

//--- rtl/rob_ram.sv
`timescale 1ns/1ps

// ============================================================
// Simple dual-port entry storage
// ============================================================
// One write port and one read port in clk
// Read address register then output register
// so rdata follows raddr by two cycles

module rob_ram
    import rob_pkg::*;
#(
    parameter int WIDTH     = ROB_DATA_BITS,
    // 1 adds a register stage in front of the write port
    parameter bit REG_WRITE = 1'b0
)
(
    input  logic             clk,

    input  logic             wen,
    input  rob_idx_t         waddr,
    input  logic [WIDTH-1:0] wdata,

    input  rob_idx_t         raddr,
    output logic [WIDTH-1:0] rdata
);

    logic [WIDTH-1:0] mem [ROB_ENTRIES];

    // Write port after the optional stage
    logic             wen_w;
    rob_idx_t         waddr_w;
    logic [WIDTH-1:0] wdata_w;

    rob_idx_t         raddr_q;

    // ============================================================
    // Write side
    // ============================================================

    generate
        if (REG_WRITE)
        begin : g_wr_reg
            always_ff @(posedge clk)
            begin
                wen_w   <= wen;
                waddr_w <= waddr;
                wdata_w <= wdata;
            end
        end
        else
        begin : g_wr_dir
            assign wen_w   = wen;
            assign waddr_w = waddr;
            assign wdata_w = wdata;
        end
    endgenerate

    always_ff @(posedge clk)
    begin
        if (wen_w)
        begin
            mem[waddr_w] <= wdata_w;
        end
    end

    // ============================================================
    // Read side
    // ============================================================

    // Address stage then data stage
    always_ff @(posedge clk)
    begin
        raddr_q <= raddr;
        rdata   <= mem[raddr_q];
    end

endmodule

//--- rob_ctrl/rob_alloc.sv
`timescale 1ns/1ps

// ============================================================
// Entry allocation
// ============================================================
// Tail pointer hands out indices in order
// Head pointer names the oldest live entry
// Occupancy counter drives the full threshold

module rob_alloc
    import rob_pkg::*;
(
    input  logic     clk,
    input  logic     enq_reset_n,

    // One allocation per cycle at most
    input  logic     alloc,
    // Oldest entry leaves the buffer
    input  logic     deq_en,

    output rob_idx_t alloc_idx,
    output rob_idx_t head_idx,
    output logic     not_full
);

    // Counter needs one extra bit to hold a full buffer
    rob_idx_t                tail_q;
    rob_idx_t                head_q;
    logic [ROB_IDX_BITS:0]   count_q;
    logic [ROB_IDX_BITS:0]   free_cnt;

    // ============================================================
    // Pointers and occupancy
    // ============================================================

    always_ff @(posedge clk)
    begin
        if (enq_reset_n)
        begin
            tail_q  <= '0;
            head_q  <= '0;
            count_q <= '0;
        end
        else
        begin
            // Index wraps modulo ROB_ENTRIES by plain overflow
            tail_q <= tail_q + rob_idx_t'(alloc);
            head_q <= head_q + rob_idx_t'(deq_en);

            // Simultaneous alloc and deq leave occupancy unchanged
            case ({alloc, deq_en})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;
            endcase
        end
    end

    // ============================================================
    // Outputs
    // ============================================================

    // Granted index is visible in the same cycle as alloc
    assign alloc_idx = tail_q;
    assign head_idx  = head_q;

    // Free entries against the threshold
    assign free_cnt = (ROB_IDX_BITS+1)'(ROB_ENTRIES) - count_q;
    assign not_full = (free_cnt >= (ROB_IDX_BITS+1)'(ROB_MIN_FREE));

    // Requester must respect not_full
    // otherwise the tail overruns a live entry
    a_alloc_not_full: assert property (
        @(posedge clk) disable iff (enq_reset_n)
        alloc |-> not_full
    ) else $error("alloc raised while buffer is full");

endmodule

//--- rob_ctrl/rob_complete_track.sv
`timescale 1ns/1ps

// ============================================================
// Completion tracking
// ============================================================
// One done bit per entry
// Payload writes pass through one register stage before they
// mark their entry complete
// The head entry's bit is the ordered output's ready flag

module rob_complete_track
    import rob_pkg::*;
(
    input  logic     clk,
    input  logic     enq_reset_n,

    // Late payload write strobe and its target
    input  logic     enq_en,
    input  rob_idx_t enq_idx,

    // Ordered side
    input  logic     deq_en,
    input  rob_idx_t head_idx,
    output logic     not_empty
);

    // Registered completion stage
    logic                   enq_en_q;
    rob_idx_t               enq_idx_q;

    // Per-entry done bits
    logic [ROB_ENTRIES-1:0] done_q;

    // ============================================================
    // Completion stage
    // ============================================================

    // Lines the done bit up with the data array's registered write
    always_ff @(posedge clk)
    begin
        if (enq_reset_n)
        begin
            enq_en_q <= 1'b0;
        end
        else
        begin
            enq_en_q <= enq_en;
        end
    end

    always_ff @(posedge clk)
    begin
        enq_idx_q <= enq_idx;
    end

    // ============================================================
    // Done bits
    // ============================================================

    always_ff @(posedge clk)
    begin
        if (enq_reset_n)
        begin
            done_q <= '0;
        end
        else
        begin
            // Set and clear never hit the same entry in one cycle
            if (enq_en_q)
            begin
                done_q[enq_idx_q] <= 1'b1;
            end
            // Consumed entry is free for reuse
            if (deq_en)
            begin
                done_q[head_idx] <= 1'b0;
            end
        end
    end

    // Oldest entry ready for readout
    assign not_empty = done_q[head_idx];

    // A second write to one allocation means the requester reused a handle
    a_no_double_done: assert property (
        @(posedge clk) disable iff (enq_reset_n)
        enq_en_q |-> !done_q[enq_idx_q]
    ) else $error("payload written twice to entry %0d", enq_idx_q);

    // Head must be complete before it is consumed
    a_deq_not_empty: assert property (
        @(posedge clk) disable iff (enq_reset_n)
        deq_en |-> not_empty
    ) else $error("deq_en raised while oldest entry is not complete");

endmodule

//--- rtl/rob_top.sv
`timescale 1ns/1ps

// ============================================================
// Reorder buffer top level
// ============================================================
// Entries are allocated in order and tagged with meta
// Payload arrives later by index in any order
// Data and meta come back in allocation order
// two cycles after deq_en

module rob_top
    import rob_pkg::*;
(
    input  logic                     clk,
    input  logic                     enq_reset_n,

    // Allocation
    input  logic                     alloc,
    input  logic [ROB_META_BITS-1:0] alloc_meta,
    output rob_idx_t                 alloc_idx,
    output logic                     not_full,

    // Late payload, no back-pressure
    input  logic                     enq_en,
    input  rob_enq_t                 enq,

    // Ordered output
    input  logic                     deq_en,
    output logic                     not_empty,
    // Valid two cycles after deq_en
    output rob_first_t               first
);

    // Oldest entry, read address of both arrays
    rob_idx_t                 head_idx;

    logic [ROB_META_BITS-1:0] meta_rdata;
    logic [ROB_DATA_BITS-1:0] data_rdata;

    // ============================================================
    // Control
    // ============================================================

    // Index handout and occupancy
    rob_alloc u_alloc (
        .clk         (clk),
        .enq_reset_n (enq_reset_n),
        .alloc       (alloc),
        .deq_en      (deq_en),
        .alloc_idx   (alloc_idx),
        .head_idx    (head_idx),
        .not_full    (not_full)
    );

    // Done bits behind a one cycle completion stage
    rob_complete_track u_track (
        .clk         (clk),
        .enq_reset_n (enq_reset_n),
        .enq_en      (enq_en),
        .enq_idx     (enq.idx),
        .deq_en      (deq_en),
        .head_idx    (head_idx),
        .not_empty   (not_empty)
    );

    // ============================================================
    // Storage
    // ============================================================

    // Meta written straight at allocation
    rob_ram #(
        .WIDTH     (ROB_META_BITS),
        .REG_WRITE (1'b0)
    ) meta_ram (
        .clk   (clk),
        .wen   (alloc),
        .waddr (alloc_idx),
        .wdata (alloc_meta),
        .raddr (head_idx),
        .rdata (meta_rdata)
    );

    // Payload write registered to match the completion stage
    rob_ram #(
        .WIDTH     (ROB_DATA_BITS),
        .REG_WRITE (1'b1)
    ) data_ram (
        .clk   (clk),
        .wen   (enq_en),
        .waddr (enq.idx),
        .wdata (enq.data),
        .raddr (head_idx),
        .rdata (data_rdata)
    );

    // Both arrays share read timing so the halves stay aligned
    assign first = '{data: data_rdata, meta: meta_rdata};

endmodule

//--- bench/rob_tb.sv
`timescale 1ns/1ps

// ============================================================
// Reorder buffer testbench
// ============================================================
// Table rows are allocated in order and written in a permuted
// rank order per group of 8
// A cycle model of head, tail, occupancy and completion checks
// the control outputs in every cycle and first two cycles
// after each dequeue

module rob_tb
    import rob_pkg::*;
();

    localparam int ROWS            = 32;
    localparam int GROUP           = 8;
    localparam int WATCHDOG_CYCLES = ROWS * 40;

    typedef struct packed {
        logic [ROB_META_BITS-1:0] meta;
        logic [ROB_DATA_BITS-1:0] data;
        logic [2:0]               rank;
    } stim_row_t;

    // Meta tag, payload, write rank within its group
    // Groups 0 and 1 write their oldest entry last
    localparam stim_row_t STIM [ROWS] = '{
        '{8'h11, 32'hd0a1_0000, 3'd7}, '{8'h22, 32'h1234_5678, 3'd2},
        '{8'h33, 32'hffff_0001, 3'd5}, '{8'h44, 32'h0000_ffff, 3'd0},
        '{8'h55, 32'hdead_beef, 3'd3}, '{8'h66, 32'h8000_0000, 3'd6},
        '{8'h77, 32'h0000_0001, 3'd1}, '{8'h88, 32'hcafe_f00d, 3'd4},
        '{8'h99, 32'h5555_aaaa, 3'd7}, '{8'haa, 32'haaaa_5555, 3'd0},
        '{8'hbb, 32'h0f0f_0f0f, 3'd1}, '{8'hcc, 32'hf0f0_f0f0, 3'd2},
        '{8'hdd, 32'h1357_9bdf, 3'd3}, '{8'hee, 32'h2468_ace0, 3'd4},
        '{8'hff, 32'h7fff_ffff, 3'd5}, '{8'h00, 32'h0bad_c0de, 3'd6},
        '{8'h01, 32'h1111_1111, 3'd1}, '{8'h02, 32'h2222_2222, 3'd0},
        '{8'h04, 32'h4444_4444, 3'd3}, '{8'h08, 32'h8888_8888, 3'd2},
        '{8'h10, 32'h0123_4567, 3'd5}, '{8'h20, 32'h89ab_cdef, 3'd4},
        '{8'h40, 32'hfedc_ba98, 3'd7}, '{8'h80, 32'h7654_3210, 3'd6},
        '{8'hfe, 32'h0000_0000, 3'd0}, '{8'hfd, 32'hffff_ffff, 3'd2},
        '{8'hfb, 32'ha5a5_a5a5, 3'd1}, '{8'hf7, 32'h5a5a_5a5a, 3'd3},
        '{8'hef, 32'h3c3c_c3c3, 3'd5}, '{8'hdf, 32'hc3c3_3c3c, 3'd4},
        '{8'hbf, 32'h600d_cafe, 3'd6}, '{8'h7f, 32'hbeef_0042, 3'd7}
    };

    // DUT signals
    logic                     clk = 1'b0;
    logic                     enq_reset_n;
    logic                     alloc;
    logic [ROB_META_BITS-1:0] alloc_meta;
    rob_idx_t                 alloc_idx;
    logic                     not_full;
    logic                     enq_en;
    rob_enq_t                 enq;
    logic                     deq_en;
    logic                     not_empty;
    rob_first_t               first;

    // Model state
    int         cyc;
    int         exp_tail;
    int         exp_head;
    int         occ;
    int         enq_cyc [ROB_ENTRIES];   // cycle of the payload write, -1 if none
    int         row_idx [ROWS];          // index granted to each row
    integer     seed;
    rob_first_t sb_q [$];                // allocation order
    rob_first_t due_val_q [$];           // dequeued, waiting for readout
    int         due_cyc_q [$];

    always #50 clk = ~clk;

    rob_top UUT (
        .clk         (clk),
        .enq_reset_n (enq_reset_n),
        .alloc       (alloc),
        .alloc_meta  (alloc_meta),
        .alloc_idx   (alloc_idx),
        .not_full    (not_full),
        .enq_en      (enq_en),
        .enq         (enq),
        .deq_en      (deq_en),
        .not_empty   (not_empty),
        .first       (first)
    );

    // ============================================================
    // Helpers
    // ============================================================

    task automatic check_eq(input logic [63:0] got, input logic [63:0] exp,
                            input string what);
        if (got !== exp)
        begin
            $display("[FAIL] %0t ns: %s got %0h expected %0h", $time, what, got, exp);
            $display("*** FAILED ***");
            $fatal(1, "stopping at first mismatch");
        end
    endtask

    // Oldest entry complete two cycles after its payload write
    function automatic bit head_ready(input int c);
        return (enq_cyc[exp_head] >= 0) && (c >= enq_cyc[exp_head] + 2);
    endfunction

    function automatic int row_of_rank(input int grp, input int rank);
        int row;
        row = -1;
        for (int i = 0; i < GROUP; i++)
            if (STIM[grp * GROUP + i].rank == rank)
                row = grp * GROUP + i;
        return row;
    endfunction

    // One clock cycle
    // Row -1 means no allocation or no payload write
    task automatic run_cycle(input int a_row, input int e_row, input bit d);
        bit         exp_not_full;
        rob_first_t exp_val;
        @(posedge clk);
        alloc  <= (a_row >= 0);
        enq_en <= (e_row >= 0);
        deq_en <= d;
        if (a_row >= 0)
            alloc_meta <= STIM[a_row].meta;
        if (e_row >= 0)
        begin
            enq.idx  <= rob_idx_t'(row_idx[e_row]);
            enq.data <= STIM[e_row].data;
        end
        cyc = cyc + 1;

        // Outputs settled mid cycle
        @(negedge clk);
        exp_not_full = (ROB_ENTRIES - occ) >= ROB_MIN_FREE;
        check_eq(not_full, exp_not_full, "not_full");
        check_eq(alloc_idx, exp_tail, "alloc_idx");
        check_eq(not_empty, head_ready(cyc), "not_empty");
        if (due_cyc_q.size() != 0 && due_cyc_q[0] == cyc)
        begin
            check_eq(first, due_val_q.pop_front(), "first");
            void'(due_cyc_q.pop_front());
        end

        // ============================================================
        // Model update for the closing edge
        // ============================================================
        if (a_row >= 0)
        begin
            row_idx[a_row] = exp_tail;
            exp_val.data   = STIM[a_row].data;
            exp_val.meta   = STIM[a_row].meta;
            sb_q.push_back(exp_val);
            exp_tail = (exp_tail + 1) % ROB_ENTRIES;
            occ++;
        end
        if (e_row >= 0)
            enq_cyc[row_idx[e_row]] = cyc;
        if (d)
        begin
            due_val_q.push_back(sb_q.pop_front());
            due_cyc_q.push_back(cyc + 2);
            enq_cyc[exp_head] = -1;
            exp_head = (exp_head + 1) % ROB_ENTRIES;
            occ--;
        end
    endtask

    // Allocate, write in rank order and drain rows lo..hi
    task automatic run_rows(input int lo, input int hi, input bit hold_deq, input bit gaps);
        int next_row;
        int wr_grp;
        int wr_rank;
        int a_row;
        int e_row;
        bit d;
        next_row = lo;
        wr_grp   = lo / GROUP;
        wr_rank  = 0;
        while (next_row <= hi || wr_grp * GROUP <= hi || sb_q.size() != 0
               || due_cyc_q.size() != 0)
        begin
            a_row = -1;
            e_row = -1;
            if (next_row <= hi && (ROB_ENTRIES - occ) >= ROB_MIN_FREE)
                a_row = next_row;
            // Next rank only once its entry was granted in an earlier cycle
            if (wr_grp * GROUP <= hi)
            begin
                e_row = row_of_rank(wr_grp, wr_rank);
                if (e_row >= next_row)
                    e_row = -1;
            end
            d = head_ready(cyc + 1);
            if (hold_deq && wr_grp * GROUP <= hi)
                d = 1'b0;
            if (gaps && ($random(seed) & 3) == 0)
                d = 1'b0;
            run_cycle(a_row, e_row, d);
            if (a_row >= 0)
                next_row++;
            if (e_row >= 0)
            begin
                wr_rank++;
                if (wr_rank == GROUP)
                begin
                    wr_grp++;
                    wr_rank = 0;
                end
            end
        end
    endtask

    // ============================================================
    // Main sequence
    // ============================================================

    initial
    begin
        seed      = 32'hb2d9_eaaf;
        cyc       = 0;
        exp_tail  = 0;
        exp_head  = 0;
        occ       = 0;
        foreach (enq_cyc[i])
            enq_cyc[i] = -1;
        enq_reset_n <= 1'b1;
        alloc       <= 1'b0;
        alloc_meta  <= '0;
        enq_en      <= 1'b0;
        enq         <= '0;
        deq_en      <= 1'b0;

        repeat (16) @(posedge clk);
        enq_reset_n <= 1'b0;

        // Idle cycle checks the reset state
        run_cycle(-1, -1, 1'b0);

        // Fill all 16 entries, oldest written last, then drain back to back
        run_rows(0, 15, 1'b1, 1'b0);

        // Steady state with wrapped indices and random dequeue gaps
        run_rows(16, ROWS - 1, 1'b0, 1'b1);

        $display("*** PASSED ***");
        $finish;
    end

    // Watchdog
    initial
    begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("Timeout: run did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("*** FAILED ***");
        $fatal(1, "watchdog expired");
    end

endmodule

//--- sources.f
common/rob_pkg.sv
rtl/rob_ram.sv
rob_ctrl/rob_alloc.sv
rob_ctrl/rob_complete_track.sv
rtl/rob_top.sv
bench/rob_tb.sv

//--- Bender.yml
package:
  name: rob

sources:
  - files:
      - common/rob_pkg.sv
      - rtl/rob_ram.sv
      - rob_ctrl/rob_alloc.sv
      - rob_ctrl/rob_complete_track.sv
      - rtl/rob_top.sv
  - target: simulation
    files:
      - bench/rob_tb.sv
